/* frame_bridge.f */
+incdir+hdl
hdl/frame_bridge_pkg.sv
hdl/rx_stream_if.sv
hdl/frame_rx_filter.sv
hdl/rx_gate_ctrl.sv
hdl/dword_packer.sv
hdl/frame_bridge_top.sv
testbench/frame_bridge_props.sv
testbench/frame_bridge_tb.sv

/* hdl/dword_packer.sv */
// Word pair packer
// Accumulates accepted 32-bit words into 64-bit beats, first word
// high; an odd last word goes out alone with 4 empty bytes

`include "frame_bridge_consts.svh"

module dword_packer
    import frame_bridge_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    rx_stream_if.sink              rx,
    input  logic                   rx_open,
    output beat_word_u             out_beat,
    output logic [`FB_EMPTY_W-1:0] out_empty,
    output logic                   out_sop,
    output logic                   out_eop,
    output logic                   out_err,
    output logic                   out_valid
);

    typedef enum logic [2:0] {
        ACC_IDLE, ACC_SOP, ACC_PARTIAL, ACC_DONE, ACC_PAUSE, ACC_EOP_GAP
    } acc_state_e;

    acc_state_e            acc_state_r, acc_state_nxt;
    logic                  accept, sop_p0, eop_p0, err_p0;
    logic                  eop_p1_r, err_lat_r;
    logic [`FB_WORD_W-1:0] prev_word_r;
    logic                  sop_nxt, eop_nxt, err_nxt, vld_nxt;
    logic [`FB_EMPTY_W-1:0] empty_p1_r;

    // Word counts only while the gate is open
    assign accept = rx.dval & rx_open;
    assign sop_p0 = rx.sop & accept;
    assign eop_p0 = rx.eop & accept;
    assign err_p0 = rx.err & accept;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            eop_p1_r  <= 1'b0;
            err_lat_r <= 1'b0;
        end else begin
            eop_p1_r <= eop_p0;
            // Held for a lone last word
            if (eop_p0) err_lat_r <= err_p0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) prev_word_r <= rx.word;
    end

    //////////////////////////////////////////////////
    // Accumulation machine
    //////////////////////////////////////////////////
    always_comb begin
        acc_state_nxt = acc_state_r;
        case (acc_state_r)
            ACC_IDLE:    if (sop_p0) acc_state_nxt = ACC_SOP;
            ACC_SOP:     if (accept) acc_state_nxt = ACC_DONE;
            ACC_PARTIAL: if (accept) acc_state_nxt = ACC_DONE;
            ACC_DONE: begin
                // Pair just closed on eop, or eop left a lone word
                if (eop_p1_r) acc_state_nxt = ACC_IDLE;
                else if (eop_p0) acc_state_nxt = ACC_EOP_GAP;
                else if (accept) acc_state_nxt = ACC_PARTIAL;
                else acc_state_nxt = ACC_PAUSE;
            end
            ACC_PAUSE:   if (accept) acc_state_nxt = ACC_PARTIAL;
            ACC_EOP_GAP: acc_state_nxt = ACC_IDLE;
            default:     acc_state_nxt = ACC_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_state_r <= ACC_IDLE;
        end else begin
            acc_state_r <= acc_state_nxt;
        end
    end

    //////////////////////////////////////////////////
    // Beat outputs
    //////////////////////////////////////////////////
    assign sop_nxt = (acc_state_r == ACC_SOP) & accept;
    assign eop_nxt = (eop_p0 & acc_state_r == ACC_PARTIAL) | (acc_state_r == ACC_EOP_GAP);
    assign err_nxt = (err_p0 & eop_p0 & acc_state_r == ACC_PARTIAL) |
                     (err_lat_r & acc_state_r == ACC_EOP_GAP);
    assign vld_nxt = (acc_state_nxt == ACC_DONE) | (acc_state_r == ACC_EOP_GAP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_sop    <= 1'b0;
            out_eop    <= 1'b0;
            out_err    <= 1'b0;
            out_valid  <= 1'b0;
            empty_p1_r <= '0;
            out_empty  <= '0;
        end else begin
            out_sop    <= sop_nxt;
            out_eop    <= eop_nxt;
            out_err    <= err_nxt;
            out_valid  <= vld_nxt;
            // Lone eop word, lines up with the gap beat
            empty_p1_r <= (eop_p0 && !vld_nxt) ? `FB_EMPTY_HALF : '0;
            out_empty  <= empty_p1_r;
        end
    end

    always_ff @(posedge clk) begin
        out_beat.pair.hi_word <= prev_word_r;
        out_beat.pair.lo_word <= rx.word;
    end

endmodule

/* hdl/frame_bridge_consts.svh */
// Frame bridge constants
// Word and beat widths, short-frame limits and the empty-byte code
// shared by the receive bridge blocks

`ifndef FRAME_BRIDGE_CONSTS_SVH
`define FRAME_BRIDGE_CONSTS_SVH

// Input word from the MAC
`define FB_WORD_W         32
// Output beat toward the extractor, two words
`define FB_BEAT_W         64

// Empty-byte count on the last beat
`define FB_EMPTY_W        3
// Only the upper word is valid
`define FB_EMPTY_HALF     3'd4

// Frames below this many words get err forced on eop
`define FB_MIN_GOOD_WORDS 4
// Saturating word counter, tops out at 7
`define FB_LEN_CNT_W      3

// Frames passed per single-step start
`define FB_STEP_CNT_W     8

`endif

/* hdl/frame_bridge_pkg.sv */
// Frame bridge types
// Output beat with its two word views, and the state encodings
// of the receive gate machines

package frame_bridge_pkg;

    `include "frame_bridge_consts.svh"

    // Word pair, first received word sits in the upper half
    typedef struct packed {
        logic [`FB_WORD_W-1:0] hi_word;
        logic [`FB_WORD_W-1:0] lo_word;
    } beat_pair_t;

    // One 64-bit beat, seen whole or as a pair
    typedef union packed {
        logic [`FB_BEAT_W-1:0] raw;
        beat_pair_t            pair;
    } beat_word_u;

    // Monitor gate, opens and closes between frames only
    typedef enum logic [1:0] {
        MON_OFF, MON_CHK_ON, MON_ON, MON_CHK_OFF
    } mon_state_e;

    // Single-step gate
    typedef enum logic [1:0] {
        STEP_IDLE, STEP_READY, STEP_CHECK, STEP_RUN
    } step_state_e;

endpackage

/* hdl/frame_bridge_top.sv */
// Receive bridge top
// MAC word stream in, 64-bit extractor beats out; input filter,
// receive gates and word packer

`include "frame_bridge_consts.svh"

module frame_bridge_top
    import frame_bridge_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`FB_WORD_W-1:0]     in_word,
    input  logic                      in_sop,
    input  logic                      in_eop,
    input  logic                      in_dval,
    input  logic                      in_err,
    input  logic                      link_enable,
    input  logic                      step_mode,
    input  logic                      step_start,
    input  logic [`FB_STEP_CNT_W-1:0] step_cnt,
    output beat_word_u                out_beat,
    output logic [`FB_EMPTY_W-1:0]    out_empty,
    output logic                      out_sop,
    output logic                      out_eop,
    output logic                      out_err,
    output logic                      out_valid,
    output logic                      short_err,
    output logic                      frame_cnt
);

    // Filtered stream, shared by gate and packer
    rx_stream_if rx_if ();

    logic rx_open;

    frame_rx_filter filter_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_word   (in_word),
        .in_sop    (in_sop),
        .in_eop    (in_eop),
        .in_dval   (in_dval),
        .in_err    (in_err),
        .rx        (rx_if),
        .short_err (short_err),
        .frame_cnt (frame_cnt)
    );

    rx_gate_ctrl gate_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx          (rx_if),
        .link_enable (link_enable),
        .step_mode   (step_mode),
        .step_start  (step_start),
        .step_cnt    (step_cnt),
        .rx_open     (rx_open)
    );

    dword_packer packer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx        (rx_if),
        .rx_open   (rx_open),
        .out_beat  (out_beat),
        .out_empty (out_empty),
        .out_sop   (out_sop),
        .out_eop   (out_eop),
        .out_err   (out_err),
        .out_valid (out_valid)
    );

endmodule

/* hdl/frame_rx_filter.sv */
// Receive input stage
// Registers the raw MAC stream, drops frames of one or two words
// and forces err on frames shorter than the minimum length

`include "frame_bridge_consts.svh"

module frame_rx_filter
    import frame_bridge_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`FB_WORD_W-1:0] in_word,
    input  logic                  in_sop,
    input  logic                  in_eop,
    input  logic                  in_dval,
    input  logic                  in_err,
    rx_stream_if.src              rx,
    output logic                  short_err,
    output logic                  frame_cnt
);

    // Eop at a word index below this gets err forced
    localparam logic [`FB_LEN_CNT_W-1:0] GOOD_LAST = `FB_MIN_GOOD_WORDS - 1;

    logic [`FB_WORD_W-1:0]   word_r;
    logic                    sop_r, eop_r, dval_r, err_r, sop_d1_r;
    logic [`FB_LEN_CNT_W-1:0] len_cnt_r;
    logic                    force_err;
    logic                    sop_f, eop_f, dval_f;

    //////////////////////////////////////////////////
    // Input register stage
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        word_r <= in_word;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sop_r    <= 1'b0;
            eop_r    <= 1'b0;
            dval_r   <= 1'b0;
            err_r    <= 1'b0;
            sop_d1_r <= 1'b0;
        end else begin
            sop_r    <= in_sop;
            eop_r    <= in_eop;
            dval_r   <= in_dval;
            // Short frames carry err from here on
            err_r    <= in_err | force_err;
            sop_d1_r <= sop_r;
        end
    end

    //////////////////////////////////////////////////
    // Short-frame error
    //////////////////////////////////////////////////
    // Saturating count of words seen before the current one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            len_cnt_r <= '0;
        end else if (in_sop && in_dval) begin
            len_cnt_r <= `FB_LEN_CNT_W'(1);
        end else if (in_dval && len_cnt_r != '1) begin
            len_cnt_r <= len_cnt_r + 1'b1;
        end
    end

    // Eop arriving before the fourth word
    assign force_err = in_eop & in_dval & (len_cnt_r < GOOD_LAST);

    //////////////////////////////////////////////////
    // Short-frame filter
    //////////////////////////////////////////////////
    // Raw eop looks one word ahead, sop_d1 one word behind
    assign sop_f  = sop_r & ~in_eop & ~eop_r;
    assign eop_f  = eop_r & ~sop_d1_r & ~sop_r;
    assign dval_f = dval_r & ~((sop_r & (in_eop | eop_r)) |
                               (eop_r & (sop_d1_r | sop_r)));

    assign rx.word = word_r;
    assign rx.sop  = sop_f & dval_f;
    assign rx.eop  = eop_f & dval_f;
    assign rx.dval = dval_f;
    assign rx.err  = err_r & dval_f;

    // One pulse per dropped frame at its registered eop word
    assign short_err = eop_r & dval_r & (sop_d1_r | sop_r);
    // Every raw frame end whether dropped or not
    assign frame_cnt = eop_r & dval_r;

endmodule

/* hdl/rx_gate_ctrl.sv */
// Receive gate control
// Monitor gate follows link_enable between frames; single-step gate
// lets a set number of frames through per start command

`include "frame_bridge_consts.svh"

module rx_gate_ctrl
    import frame_bridge_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    rx_stream_if.mon                  rx,
    input  logic                      link_enable,
    input  logic                      step_mode,
    input  logic                      step_start,
    input  logic [`FB_STEP_CNT_W-1:0] step_cnt,
    output logic                      rx_open
);

    mon_state_e                mon_state_r, mon_state_nxt;
    step_state_e               step_state_r, step_state_nxt;
    logic [`FB_STEP_CNT_W-1:0] step_ctr_r;

    //////////////////////////////////////////////////
    // Monitor gate
    //////////////////////////////////////////////////
    always_comb begin
        mon_state_nxt = mon_state_r;
        case (mon_state_r)
            MON_OFF:     if (link_enable) mon_state_nxt = MON_CHK_ON;
            // Wait for a gap before opening
            MON_CHK_ON:  if (!rx.dval) mon_state_nxt = MON_ON;
            MON_ON:      if (!link_enable) mon_state_nxt = MON_CHK_OFF;
            // Let the frame in flight finish
            MON_CHK_OFF: if (!rx.dval) mon_state_nxt = MON_OFF;
            default:     mon_state_nxt = MON_OFF;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mon_state_r <= MON_OFF;
        end else begin
            mon_state_r <= mon_state_nxt;
        end
    end

    //////////////////////////////////////////////////
    // Single-step gate
    //////////////////////////////////////////////////
    always_comb begin
        step_state_nxt = step_state_r;
        case (step_state_r)
            STEP_IDLE: begin
                if (step_mode && !rx.dval) step_state_nxt = STEP_READY;
            end
            STEP_READY: begin
                if (!step_mode) step_state_nxt = STEP_IDLE;
                else if (step_start) step_state_nxt = STEP_CHECK;
            end
            // No frame mid-flight when the gate opens
            STEP_CHECK: begin
                if (!rx.dval) step_state_nxt = STEP_RUN;
            end
            STEP_RUN: begin
                if (step_ctr_r == step_cnt) step_state_nxt = STEP_IDLE;
            end
            default: step_state_nxt = STEP_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_state_r <= STEP_IDLE;
        end else begin
            step_state_r <= step_state_nxt;
        end
    end

    // Frames passed in this run
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_ctr_r <= '0;
        end else if (step_state_r == STEP_CHECK) begin
            step_ctr_r <= '0;
        end else if (rx.eop && step_state_r == STEP_RUN) begin
            step_ctr_r <= step_ctr_r + 1'b1;
        end
    end

    // Both gates must agree
    assign rx_open = (mon_state_r == MON_ON || mon_state_r == MON_CHK_OFF) &&
                     (step_state_r == STEP_IDLE || step_state_r == STEP_RUN);

endmodule

/* hdl/rx_stream_if.sv */
// Filtered receive word stream
// Valid-only, no back-pressure; sop and eop qualified by dval,
// err meaningful on the eop word

`include "frame_bridge_consts.svh"

interface rx_stream_if;

    logic [`FB_WORD_W-1:0] word;
    logic                  sop;
    logic                  eop;
    logic                  dval;
    logic                  err;

    // Filter side
    modport src (output word, sop, eop, dval, err);

    // Packer side
    modport sink (input word, sop, eop, dval, err);

    // Gate control only watches framing
    modport mon (input dval, eop);

endinterface

/* testbench/frame_bridge_props.sv */
// Output stream checks for the receive bridge
// Framing flags and the empty code must line up with out_valid,
// and no beat leaves right after reset

`include "frame_bridge_consts.svh"

module frame_bridge_props (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   out_valid,
    input logic                   out_sop,
    input logic                   out_eop,
    input logic [`FB_EMPTY_W-1:0] out_empty
);

    // Failed assertions so far, read by the testbench at the end
    int assert_fail_cnt = 0;

    sop_valid_a: assert property (@(posedge clk) disable iff (!rst_n) out_sop |-> out_valid)
        else begin
            $error("out_sop seen without out_valid");
            assert_fail_cnt++;
        end

    eop_valid_a: assert property (@(posedge clk) disable iff (!rst_n) out_eop |-> out_valid)
        else begin
            $error("out_eop seen without out_valid");
            assert_fail_cnt++;
        end

    // Empty bytes only on the last beat of a frame
    empty_eop_a: assert property (@(posedge clk) disable iff (!rst_n)
                                  (out_empty != '0) |-> out_eop)
        else begin
            $error("nonzero out_empty without out_eop");
            assert_fail_cnt++;
        end

    first_idle_a: assert property (@(posedge clk) $rose(rst_n) |-> !out_valid)
        else begin
            $error("out_valid high in the cycle after reset release");
            assert_fail_cnt++;
        end

endmodule

bind frame_bridge_top frame_bridge_props props_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .out_valid (out_valid),
    .out_sop   (out_sop),
    .out_eop   (out_eop),
    .out_empty (out_empty)
);

/* testbench/frame_bridge_tb.sv */
// Receive bridge testbench
// Sends a table of frames through the bridge, rebuilds the expected
// 64-bit beats from the framing rules and checks beats and pulse counts

`include "frame_bridge_consts.svh"

module frame_bridge_tb
    import frame_bridge_pkg::*;
();

    typedef struct packed {
        beat_word_u             beat;
        logic [`FB_EMPTY_W-1:0] empty;
        logic                   sop;
        logic                   eop;
        logic                   err;
    } beat_rec_t;

    typedef struct {
        int len;
        bit raw_err;
        bit link;
        bit step;
        int step_n;
        int burst;
        int pass;
    } row_t;

    localparam int N_ROWS = 11;

    logic                      clk, rst_n;
    logic [`FB_WORD_W-1:0]     in_word;
    logic                      in_sop, in_eop, in_dval, in_err;
    logic                      link_enable, step_mode, step_start;
    logic [`FB_STEP_CNT_W-1:0] step_cnt;
    beat_word_u                out_beat;
    logic [`FB_EMPTY_W-1:0]    out_empty;
    logic                      out_sop, out_eop, out_err, out_valid;
    logic                      short_err, frame_cnt;

    row_t                  rows [N_ROWS];
    beat_rec_t             exp_q[$];
    beat_rec_t             got_q[$];
    logic [`FB_WORD_W-1:0] frame_words[$];
    logic [31:0]           lcg_state = 32'd64;
    int                    short_tally = 0;
    int                    frame_tally = 0;

    frame_bridge_top dut_i (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    //////////////////////////////////////////////////
    // Collector samples just after the falling edge
    //////////////////////////////////////////////////
    always @(negedge clk) begin
        #1;
        if (rst_n) begin
            if (out_valid) got_q.push_back({out_beat, out_empty, out_sop, out_eop, out_err});
            if (short_err) short_tally++;
            if (frame_cnt) frame_tally++;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_beat(input beat_word_u got_beat, input beat_word_u exp_beat,
                              input logic [`FB_EMPTY_W-1:0] got_empty,
                              input logic [`FB_EMPTY_W-1:0] exp_empty,
                              input logic [2:0] got_flags, input logic [2:0] exp_flags);
        bit bad;
        bad = (got_beat.pair.hi_word !== exp_beat.pair.hi_word) ||
              (got_empty !== exp_empty) || (got_flags !== exp_flags);
        // Lower word is padding on a half beat
        if (exp_empty == '0 && got_beat.pair.lo_word !== exp_beat.pair.lo_word) bad = 1'b1;
        if (bad) fail_stop($sformatf(
            "** Error @%0t: beat %h empty %0d flags %b, expected %h empty %0d flags %b",
            $time, got_beat.raw, got_empty, got_flags, exp_beat.raw, exp_empty, exp_flags));
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp)
            fail_stop($sformatf("** Error @%0t: %s is %0d, expected %0d", $time, what, got, exp));
    endtask

    //////////////////////////////////////////////////
    // Waits with their own limits
    //////////////////////////////////////////////////
    task automatic wait_gate(input logic level);
        int n;
        n = 0;
        while (dut_i.rx_open !== level) begin
            @(negedge clk);
            n++;
            if (n > 40) fail_stop($sformatf("Timeout: receive gate never went to %0b", level));
        end
    endtask

    task automatic wait_frames(input int total);
        int n;
        n = 0;
        while (frame_tally < total) begin
            @(negedge clk);
            n++;
            if (n > 200) fail_stop("Timeout: frame_cnt pulses did not all arrive");
        end
    endtask

    task automatic wait_beats(input int total);
        int n;
        n = 0;
        while (got_q.size() < total) begin
            @(negedge clk);
            n++;
            if (n > 200) fail_stop("Timeout: output beats did not all arrive");
        end
    endtask

    // Expected beats of one passed frame; err forced below the minimum length
    task automatic expect_frame(input bit raw_err);
        beat_rec_t rec;
        int        n;
        logic      err_eop;
        n = frame_words.size();
        err_eop = raw_err || (n < `FB_MIN_GOOD_WORDS);
        for (int i = 0; i + 1 < n; i += 2) begin
            rec.beat.pair.hi_word = frame_words[i];
            rec.beat.pair.lo_word = frame_words[i + 1];
            rec.empty = '0;
            rec.sop = (i == 0);
            rec.eop = (i + 2 == n);
            rec.err = rec.eop && err_eop;
            exp_q.push_back(rec);
        end
        // Odd count leaves the last word alone in the upper half
        if (n % 2 == 1) begin
            rec.beat.pair.hi_word = frame_words[n - 1];
            rec.beat.pair.lo_word = '0;
            rec.empty = `FB_EMPTY_HALF;
            rec.sop = 1'b0;
            rec.eop = 1'b1;
            rec.err = err_eop;
            exp_q.push_back(rec);
        end
    endtask

    // One frame with dval every cycle and a two-cycle gap after it
    task automatic send_frame(input int len, input bit raw_err, input bit passes);
        frame_words.delete();
        for (int k = 0; k < len; k++) begin
            @(negedge clk);
            lcg_state = lcg_next(lcg_state);
            in_word = lcg_state;
            in_sop = (k == 0);
            in_eop = (k == len - 1);
            in_dval = 1'b1;
            in_err = raw_err && (k == len - 1);
            frame_words.push_back(lcg_state);
        end
        repeat (2) begin
            @(negedge clk);
            in_sop = 1'b0;
            in_eop = 1'b0;
            in_dval = 1'b0;
            in_err = 1'b0;
        end
        if (passes && len >= 3) expect_frame(raw_err);
    endtask

    task automatic run_row(input row_t r);
        int        short0;
        int        frame0;
        beat_rec_t got;
        beat_rec_t exp;
        @(negedge clk);
        link_enable = r.link;
        step_mode = r.step;
        step_cnt = r.step_n;
        // Gate closed when the link is off or a step run waits for start
        wait_gate(r.link && !r.step);
        if (r.link && r.step) begin
            @(negedge clk);
            step_start = 1'b1;
            @(negedge clk);
            step_start = 1'b0;
            wait_gate(1'b1);
        end
        // Anything collected by now came late from the previous row
        check_count("beats left over from the previous row", got_q.size(), 0);
        short0 = short_tally;
        frame0 = frame_tally;
        for (int f = 0; f < r.burst; f++) send_frame(r.len, r.raw_err, f < r.pass);
        wait_frames(frame0 + r.burst);
        wait_beats(exp_q.size());
        check_count("frame_cnt pulses", frame_tally - frame0, r.burst);
        check_count("short_err pulses", short_tally - short0, (r.len <= 2) ? r.burst : 0);
        check_count("output beats", got_q.size(), exp_q.size());
        while (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            got = got_q.pop_front();
            check_beat(got.beat, exp.beat, got.empty, exp.empty,
                       {got.sop, got.eop, got.err}, {exp.sop, exp.eop, exp.err});
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        rst_n = 1'b0;
        in_word = '0;
        in_sop = 1'b0;
        in_eop = 1'b0;
        in_dval = 1'b0;
        in_err = 1'b0;
        link_enable = 1'b0;
        step_mode = 1'b0;
        step_start = 1'b0;
        step_cnt = '0;
        // len, raw err, link_enable, step_mode, step_cnt, burst, frames passed
        rows = '{'{8, 0, 1, 0, 0, 1, 1}, '{5, 1, 1, 0, 0, 1, 1}, '{5, 0, 1, 0, 0, 1, 1},
                 '{1, 0, 1, 0, 0, 1, 0}, '{2, 1, 1, 0, 0, 1, 0}, '{3, 0, 1, 0, 0, 1, 1},
                 '{4, 1, 1, 0, 0, 2, 2}, '{6, 0, 0, 0, 0, 2, 0}, '{7, 0, 1, 0, 0, 1, 1},
                 '{4, 0, 1, 1, 2, 4, 2}, '{4, 0, 1, 0, 0, 1, 1}};
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < N_ROWS; i++) run_row(rows[i]);
        // Late beats would show up in this quiet tail
        repeat (10) @(negedge clk);
        check_count("beats after the last row", got_q.size(), 0);
        if (dut_i.props_i.assert_fail_cnt != 0) begin
            fail_stop("Output stream assertions failed during the run");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule
